/* design/rv_bridge_pkg.sv */
// softcore to sdram bridge, shared definitions
// widths, data types and the access plan used by all stages

package rv_bridge_pkg;

    localparam int RV_ADDR_W = 23;   // softcore byte address
    localparam int HALF_W    = 16;   // one sdram access

    typedef logic [2*HALF_W-1:0] word_t;     // softcore data word
    typedef logic [HALF_W-1:0]   half_t;     // sdram half word
    typedef logic [3:0]          strb_t;     // one strobe per byte of word_t
    typedef logic [1:0]          lane_t;     // byte masks of one half, active high

    // how a request is split into half accesses
    typedef enum logic [1:0] {
        PLAN_BOTH    = 2'd0,   // word 0, then word 1
        PLAN_LO_ONLY = 2'd1,   // word 0 only
        PLAN_HI_ONLY = 2'd2    // word 1 only
    } plan_t;

endpackage

/* design/rv_word_decode.sv */
// softcore request decode
// finds rising edges of valid, keeps one pending request and
// captures the command with its half-access plan

`timescale 1ns/1ps

module rv_word_decode #(
    parameter int p_addr_w = rv_bridge_pkg::RV_ADDR_W
) (
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  logic                  i_rv_valid,
    input  logic [p_addr_w-1:0]   i_rv_addr,
    input  rv_bridge_pkg::word_t  i_rv_wdata,
    input  rv_bridge_pkg::strb_t  i_rv_wstrb,
    input  logic                  i_seq_idle,
    output logic                  o_cmd_start,
    output logic [p_addr_w-1:0]   o_cmd_addr,
    output rv_bridge_pkg::word_t  o_cmd_wdata,
    output logic                  o_cmd_write,
    output rv_bridge_pkg::plan_t  o_cmd_plan,
    output rv_bridge_pkg::lane_t  o_cmd_ds_lo,
    output rv_bridge_pkg::lane_t  o_cmd_ds_hi
);
    import rv_bridge_pkg::*;

    logic  valid_r;
    logic  pending;
    logic  rise;
    logic  accept;
    logic  is_write;
    plan_t plan_next;

    assign rise     = i_rv_valid & ~valid_r;
    // start pulse still in flight means the sequencer is not really idle
    assign accept   = (rise | pending) & i_seq_idle & ~o_cmd_start;
    assign is_write = |i_rv_wstrb;

    always_comb begin
        plan_next = PLAN_BOTH;
        if (is_write && i_rv_wstrb[1:0] == 2'b00)
            plan_next = PLAN_HI_ONLY;        // upper bytes only
        else if (is_write && i_rv_wstrb[3:2] == 2'b00)
            plan_next = PLAN_LO_ONLY;        // lower bytes only
    end

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            valid_r     <= 1'b0;
            pending     <= 1'b0;
            o_cmd_start <= 1'b0;
        end else begin
            valid_r     <= i_rv_valid;
            o_cmd_start <= accept;
            if (accept)
                pending <= 1'b0;
            else if (rise)
                pending <= 1'b1;    // busy, remember it
        end
    end

    // command fields, stable until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            o_cmd_addr  <= i_rv_addr;
            o_cmd_wdata <= i_rv_wdata;
            o_cmd_write <= is_write;
            o_cmd_plan  <= plan_next;
            o_cmd_ds_lo <= is_write ? i_rv_wstrb[1:0] : 2'b11;   // reads take full halves
            o_cmd_ds_hi <= is_write ? i_rv_wstrb[3:2] : 2'b11;
        end
    end

endmodule

/* design/rv_half_sequencer.sv */
// half-word access sequencer
// issues one or two 16-bit accesses on the toggle req/ack port and
// signals when read halves can be captured and when the request is done

`timescale 1ns/1ps

module rv_half_sequencer #(
    parameter int p_addr_w = rv_bridge_pkg::RV_ADDR_W
) (
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  logic                  i_cmd_start,
    input  logic [p_addr_w-1:0]   i_cmd_addr,
    input  rv_bridge_pkg::word_t  i_cmd_wdata,
    input  logic                  i_cmd_write,
    input  rv_bridge_pkg::plan_t  i_cmd_plan,
    input  rv_bridge_pkg::lane_t  i_cmd_ds_lo,
    input  rv_bridge_pkg::lane_t  i_cmd_ds_hi,
    input  logic                  i_mem_ack,
    output logic                  o_seq_idle,
    output logic                  o_mem_req,
    output logic [p_addr_w-2:0]   o_mem_addr,
    output rv_bridge_pkg::half_t  o_mem_wdata,
    output rv_bridge_pkg::lane_t  o_mem_ds,
    output logic                  o_mem_we,
    output logic                  o_cap_lo,
    output logic                  o_cap_hi,
    output logic                  o_seq_done
);
    import rv_bridge_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_LO,
        ST_DATA_LO,
        ST_WAIT_HI,
        ST_DATA_HI
    } state_t;

    state_t              state;
    logic                acked;
    logic                hi_only;
    half_t               wdata_lo;
    half_t               wdata_hi;
    logic [p_addr_w-3:0] row_addr;     // address bits above the word select

    assign acked    = (o_mem_req == i_mem_ack);    // nothing outstanding
    assign hi_only  = (i_cmd_plan == PLAN_HI_ONLY);
    assign wdata_lo = i_cmd_wdata[HALF_W-1:0];
    assign wdata_hi = i_cmd_wdata[2*HALF_W-1:HALF_W];
    assign row_addr = i_cmd_addr[p_addr_w-1:2];

    assign o_seq_idle = (state == ST_IDLE);
    assign o_cap_lo   = (state == ST_DATA_LO);     // lower read half on the port
    assign o_cap_hi   = (state == ST_DATA_HI);

    //////////////////////////////////////////////////
    // access payload, set up with each request toggle
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_cmd_start) begin
            o_mem_addr  <= {row_addr, hi_only};
            o_mem_wdata <= hi_only ? wdata_hi : wdata_lo;
            o_mem_ds    <= hi_only ? i_cmd_ds_hi : i_cmd_ds_lo;
        end else if (state == ST_WAIT_LO && acked) begin
            o_mem_addr  <= {row_addr, 1'b1};   // word 1
            o_mem_wdata <= wdata_hi;
            o_mem_ds    <= i_cmd_ds_hi;
        end
    end

    //////////////////////////////////////////////////
    // control fsm
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state      <= ST_IDLE;
            o_mem_req  <= 1'b0;
            o_mem_we   <= 1'b0;
            o_seq_done <= 1'b0;
        end else begin
            o_seq_done <= 1'b0;
            case (state)
                ST_IDLE: if (i_cmd_start) begin
                    o_mem_req <= ~o_mem_req;
                    o_mem_we  <= i_cmd_write;
                    state     <= hi_only ? ST_WAIT_HI : ST_WAIT_LO;
                end
                ST_WAIT_LO: if (acked) begin
                    if (i_cmd_write && i_cmd_plan == PLAN_LO_ONLY) begin
                        o_seq_done <= 1'b1;         // single lower access
                        state      <= ST_IDLE;
                    end else begin
                        o_mem_req <= ~o_mem_req;    // second half right away
                        state     <= i_cmd_write ? ST_WAIT_HI : ST_DATA_LO;
                    end
                end
                ST_DATA_LO: state <= ST_WAIT_HI;
                ST_WAIT_HI: if (acked) begin
                    o_seq_done <= 1'b1;
                    state      <= i_cmd_write ? ST_IDLE : ST_DATA_HI;
                end
                ST_DATA_HI: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* design/rv_read_assemble.sv */
// read word assembly
// keeps the lower half, joins it with the upper half into the 32-bit
// read word and pulses ready together with the data

`timescale 1ns/1ps

module rv_read_assemble (
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  rv_bridge_pkg::half_t  i_mem_dout,
    input  logic                  i_cap_lo,
    input  logic                  i_cap_hi,
    input  logic                  i_seq_done,
    output rv_bridge_pkg::word_t  o_rv_rdata,
    output logic                  o_rv_ready
);
    import rv_bridge_pkg::*;

    half_t dout_lo;    // word 0 of the current read

    always_ff @(posedge clk) begin
        if (i_cap_lo)
            dout_lo <= i_mem_dout;
        if (i_cap_hi)
            o_rv_rdata <= {i_mem_dout, dout_lo};   // held until next read
    end

    // ready lines up with the registered word
    always_ff @(posedge clk) begin
        if (!sys_resetn)
            o_rv_ready <= 1'b0;
        else
            o_rv_ready <= i_seq_done;
    end

endmodule

/* design/rv_bridge_top.sv */
// softcore to sdram bridge
// splits 32-bit softcore requests into 16-bit toggle-handshake
// accesses and returns the assembled read word

`timescale 1ns/1ps

module rv_bridge_top #(
    parameter int p_addr_w = rv_bridge_pkg::RV_ADDR_W
) (
    input  logic                  clk,
    input  logic                  sys_resetn,
    // softcore side
    input  logic                  i_rv_valid,
    input  logic [p_addr_w-1:0]   i_rv_addr,
    input  rv_bridge_pkg::word_t  i_rv_wdata,
    input  rv_bridge_pkg::strb_t  i_rv_wstrb,
    output rv_bridge_pkg::word_t  o_rv_rdata,
    output logic                  o_rv_ready,
    // sdram port
    output logic                  o_mem_req,
    output logic [p_addr_w-2:0]   o_mem_addr,
    output rv_bridge_pkg::half_t  o_mem_wdata,
    output rv_bridge_pkg::lane_t  o_mem_ds,
    output logic                  o_mem_we,
    input  logic                  i_mem_ack,
    input  rv_bridge_pkg::half_t  i_mem_dout
);
    import rv_bridge_pkg::*;

    // decode to execute
    logic                cmd_start;
    logic [p_addr_w-1:0] cmd_addr;
    word_t               cmd_wdata;
    logic                cmd_write;
    plan_t               cmd_plan;
    lane_t               cmd_ds_lo;
    lane_t               cmd_ds_hi;
    // execute to decode / result
    logic                seq_idle;
    logic                cap_lo;
    logic                cap_hi;
    logic                seq_done;

    rv_word_decode #(.p_addr_w(p_addr_w)) rv_word_decode_i (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_rv_valid(i_rv_valid), .i_rv_addr(i_rv_addr),
        .i_rv_wdata(i_rv_wdata), .i_rv_wstrb(i_rv_wstrb),
        .i_seq_idle(seq_idle),
        .o_cmd_start(cmd_start), .o_cmd_addr(cmd_addr), .o_cmd_wdata(cmd_wdata),
        .o_cmd_write(cmd_write), .o_cmd_plan(cmd_plan),
        .o_cmd_ds_lo(cmd_ds_lo), .o_cmd_ds_hi(cmd_ds_hi)
    );

    rv_half_sequencer #(.p_addr_w(p_addr_w)) rv_half_sequencer_i (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_cmd_start(cmd_start), .i_cmd_addr(cmd_addr), .i_cmd_wdata(cmd_wdata),
        .i_cmd_write(cmd_write), .i_cmd_plan(cmd_plan),
        .i_cmd_ds_lo(cmd_ds_lo), .i_cmd_ds_hi(cmd_ds_hi),
        .i_mem_ack(i_mem_ack),
        .o_seq_idle(seq_idle), .o_mem_req(o_mem_req), .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata), .o_mem_ds(o_mem_ds), .o_mem_we(o_mem_we),
        .o_cap_lo(cap_lo), .o_cap_hi(cap_hi), .o_seq_done(seq_done)
    );

    rv_read_assemble rv_read_assemble_i (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_mem_dout(i_mem_dout),
        .i_cap_lo(cap_lo), .i_cap_hi(cap_hi), .i_seq_done(seq_done),
        .o_rv_rdata(o_rv_rdata), .o_rv_ready(o_rv_ready)
    );

endmodule

/* tb/sdram_half_model.sv */
// sdram half-word model
// 16-bit memory behind the toggle req/ack port, answers each request
// after a pseudo random delay of 0 to 7 cycles, honours byte enables

`timescale 1ns/1ps

module sdram_half_model #(
    parameter int p_mem_aw = 22
) (
    input  logic                  clk,
    input  logic                  sys_resetn,
    input  logic                  i_req,
    input  logic [p_mem_aw-1:0]   i_addr,
    input  rv_bridge_pkg::half_t  i_wdata,
    input  rv_bridge_pkg::lane_t  i_ds,
    input  logic                  i_we,
    output logic                  o_ack,
    output rv_bridge_pkg::half_t  o_dout
);
    import rv_bridge_pkg::*;

    half_t       mem [logic [p_mem_aw-1:0]];
    logic [15:0] lfsr;
    logic        busy;
    logic [2:0]  wait_cnt;

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // untouched words read back a pattern of their whole address
    function automatic half_t fill_word(input logic [p_mem_aw-1:0] a);
        logic [31:0] w;
        w = 32'(a);
        return w[15:0] ^ w[31:16] ^ 16'h3c5a;
    endfunction

    always @(posedge clk) begin : model_proc
        logic [15:0] s;
        logic [2:0]  d;
        half_t       cur;
        if (!sys_resetn) begin
            o_ack <= 1'b0;
            busy  <= 1'b0;
            lfsr  <= 16'd14;
        end else if (!busy && i_req != o_ack) begin
            s = lfsr;
            d = 3'd0;
            for (int b = 0; b < 3; b++) begin   // one step per delay bit
                s = lfsr_step(s);
                d = {d[1:0], s[0]};
            end
            lfsr     <= s;
            wait_cnt <= d;
            busy     <= 1'b1;
        end else if (busy) begin
            if (wait_cnt == 3'd0) begin
                cur = mem.exists(i_addr) ? mem[i_addr] : fill_word(i_addr);
                if (i_we) begin
                    if (i_ds[0]) cur[7:0]  = i_wdata[7:0];
                    if (i_ds[1]) cur[15:8] = i_wdata[15:8];
                    mem[i_addr] = cur;
                end else begin
                    o_dout <= cur;
                end
                o_ack <= i_req;     // access complete
                busy  <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 3'd1;
            end
        end
    end

endmodule

/* tb/tb_rv_bridge.sv */
// testbench for the softcore to sdram bridge
// replays the case file against a shadow word array, counts the half
// accesses of each request and watches the ready pulses

`timescale 1ns/1ps

module tb_rv_bridge;
    import rv_bridge_pkg::*;

    localparam int ADDR_W = RV_ADDR_W;

    logic              clk = 1'b0;
    logic              sys_resetn;
    logic              i_rv_valid;
    logic [ADDR_W-1:0] i_rv_addr;
    word_t             i_rv_wdata;
    strb_t             i_rv_wstrb;
    word_t             o_rv_rdata;
    logic              o_rv_ready;
    logic              o_mem_req;
    logic [ADDR_W-2:0] o_mem_addr;
    half_t             o_mem_wdata;
    lane_t             o_mem_ds;
    logic              o_mem_we;
    logic              i_mem_ack;
    half_t             i_mem_dout;

    byte               op_q[$];
    logic [ADDR_W-1:0] addr_q[$];
    word_t             wdata_q[$];
    strb_t             strb_q[$];
    word_t             exp_q[$];
    word_t             shadow [logic [ADDR_W-1:0]];

    int   n_cases = 0;
    bit   cases_loaded = 0;
    int   val_errs = 0;
    int   proto_errs = 0;
    int   req_cnt = 0;
    int   ready_cnt = 0;
    int   acc_cnt = 0;
    logic [1:0] sel_seen = 2'b00;
    logic req_prev = 1'b0;

    always #20 clk = ~clk;     // 40 ns period

    rv_bridge_top #(.p_addr_w(ADDR_W)) rv_bridge_top_i (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_rv_valid(i_rv_valid), .i_rv_addr(i_rv_addr),
        .i_rv_wdata(i_rv_wdata), .i_rv_wstrb(i_rv_wstrb),
        .o_rv_rdata(o_rv_rdata), .o_rv_ready(o_rv_ready),
        .o_mem_req(o_mem_req), .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
        .o_mem_ds(o_mem_ds), .o_mem_we(o_mem_we),
        .i_mem_ack(i_mem_ack), .i_mem_dout(i_mem_dout)
    );

    sdram_half_model #(.p_mem_aw(ADDR_W-1)) sdram_half_model_i (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_req(o_mem_req), .i_addr(o_mem_addr), .i_wdata(o_mem_wdata),
        .i_ds(o_mem_ds), .i_we(o_mem_we),
        .o_ack(i_mem_ack), .o_dout(i_mem_dout)
    );

    // byte merge under the strobes
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t st);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++)
            if (st[b]) r[8*b +: 8] = new_w[8*b +: 8];
        return r;
    endfunction

    // how many half accesses a request needs, and to which words
    function automatic int expected_accesses(input strb_t st, output logic [1:0] sels);
        sels = 2'b11;
        if (st == 4'h0) return 2;          // reads take both halves
        if (st[1:0] == 2'b00) begin
            sels = 2'b10;
            return 1;
        end
        if (st[3:2] == 2'b00) begin
            sels = 2'b01;
            return 1;
        end
        return 2;
    endfunction

    //////////////////////////////////////////////////
    // port monitor sampled mid cycle
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (o_rv_ready) begin
            ready_cnt++;
            assert (o_mem_req == i_mem_ack) else begin
                $display("ready pulsed at %0t with an access still outstanding", $time);
                proto_errs++;
            end
        end
        if (o_mem_req !== req_prev) begin
            acc_cnt++;
            sel_seen[o_mem_addr[0]] = 1'b1;
            // row bits come from the byte address above the word select
            assert (o_mem_addr[ADDR_W-2:1] == i_rv_addr[ADDR_W-1:2]) else begin
                $display("FAIL %0t: access to half word %h for byte address %h",
                         $time, o_mem_addr, i_rv_addr);
                val_errs++;
            end
        end
        req_prev = o_mem_req;
    end

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!o_rv_ready && n < 200) begin
            @(negedge clk);
            n++;
        end
        assert (o_rv_ready) else begin
            $display("no ready pulse within 200 cycles at %0t", $time);
            proto_errs++;
        end
    endtask

    task automatic run_case(input int i);
        logic [1:0] sels;
        int         n_exp;
        word_t      exp_w;
        acc_cnt  = 0;
        sel_seen = 2'b00;
        @(posedge clk);
        #2;
        i_rv_valid = 1'b1;
        i_rv_addr  = addr_q[i];
        i_rv_wdata = wdata_q[i];
        i_rv_wstrb = (op_q[i] == "W") ? strb_q[i] : 4'h0;
        req_cnt++;
        wait_ready();
        n_exp = expected_accesses(i_rv_wstrb, sels);
        assert (acc_cnt == n_exp && sel_seen == sels) else begin
            $display("FAIL %0t: case %0d made %0d accesses to words %b, expected %0d to %b",
                     $time, i, acc_cnt, sel_seen, n_exp, sels);
            val_errs++;
        end
        if (op_q[i] == "W") begin
            exp_w = shadow.exists(addr_q[i]) ? shadow[addr_q[i]] : 32'h0;
            shadow[addr_q[i]] = merge_bytes(exp_w, wdata_q[i], strb_q[i]);
        end else begin
            assert (o_rv_rdata == shadow[addr_q[i]] && o_rv_rdata == exp_q[i]) else begin
                $display("FAIL %0t: case %0d read %h, shadow %h, file %h", $time, i,
                         o_rv_rdata, shadow[addr_q[i]], exp_q[i]);
                val_errs++;
            end
        end
        @(posedge clk);
        #2;
        i_rv_valid = 1'b0;
    endtask

    // second rising edge of valid while the first write is still running
    task automatic run_pending_pair();
        @(posedge clk);
        #2;
        i_rv_valid = 1'b1;
        i_rv_addr  = 23'h000300;
        i_rv_wdata = 32'h5a5aa5a5;
        i_rv_wstrb = 4'hf;
        req_cnt++;
        @(posedge clk);
        #2;
        i_rv_valid = 1'b0;
        i_rv_wstrb = 4'h0;     // follow-up is a read
        @(posedge clk);
        #2;
        i_rv_valid = 1'b1;
        req_cnt++;
        shadow[23'h000300] = 32'h5a5aa5a5;
        wait_ready();
        wait_ready();
        assert (o_rv_rdata == 32'h5a5aa5a5) else begin
            $display("FAIL %0t: pending read returned %h, expected 5a5aa5a5",
                     $time, o_rv_rdata);
            val_errs++;
        end
        @(posedge clk);
        #2;
        i_rv_valid = 1'b0;
    endtask

    task automatic load_cases();
        int    fd;
        int    r;
        string line;
        byte   op;
        logic [31:0] a;
        word_t wd;
        logic [31:0] st;
        word_t ex;
        fd = $fopen("tb/bridge_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file tb/bridge_cases.txt");
            proto_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            if (line.len() < 5 || line.substr(0, 0) == "#")
                continue;
            r = $sscanf(line, "%c %h %h %h %h", op, a, wd, st, ex);
            op_q.push_back(op);
            addr_q.push_back(a[ADDR_W-1:0]);
            wdata_q.push_back(wd);
            strb_q.push_back(st[3:0]);
            exp_q.push_back(ex);
        end
        $fclose(fd);
        n_cases = op_q.size();
    endtask

    // watchdog
    initial begin
        wait (cases_loaded);
        repeat (n_cases * 40 + 200) @(posedge clk);
        $display("watchdog timeout, the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        sys_resetn = 1'b0;
        i_rv_valid = 1'b0;
        i_rv_addr  = '0;
        i_rv_wdata = '0;
        i_rv_wstrb = '0;
        repeat (4) @(posedge clk);
        #2;
        sys_resetn = 1'b1;
        @(negedge clk);
        assert (o_rv_ready == 1'b0 && o_mem_req == 1'b0 && o_mem_we == 1'b0) else begin
            $display("FAIL %0t: outputs not idle after reset", $time);
            val_errs++;
        end
        load_cases();
        cases_loaded = 1;
        for (int i = 0; i < n_cases; i++)
            run_case(i);
        run_pending_pair();
        repeat (4) @(posedge clk);
        assert (ready_cnt == req_cnt) else begin
            $display("ready pulsed %0d times for %0d requests", ready_cnt, req_cnt);
            proto_errs++;
        end
        $display("%0d cases, %0d value errors, %0d protocol errors",
                 n_cases, val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0 && n_cases > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
design/rv_bridge_pkg.sv
design/rv_word_decode.sv
design/rv_half_sequencer.sv
design/rv_read_assemble.sv
design/rv_bridge_top.sv
tb/sdram_half_model.sv
tb/tb_rv_bridge.sv

/* Makefile */
# Verilator build and run for the softcore to sdram bridge testbench

TOP := tb_rv_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f build.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > run.log 2>&1 || true
	@cat run.log
	@grep -q '\*\*\* PASSED \*\*\*' run.log

clean:
	rm -rf obj_dir run.log

/* tb/bridge_cases.txt */
# op addr(hex, byte) wdata(hex) wstrb(hex) expected_rdata(hex)
# R lines use wstrb 0, W lines ignore the last column
W 000100 12345678 f 00000000
R 000100 00000000 0 12345678
W 000100 aabbccdd c 00000000
R 000100 00000000 0 aabb5678
W 000100 11223344 3 00000000
R 000100 00000000 0 aabb3344
W 000100 99887766 9 00000000
R 000100 00000000 0 99bb3366
W 7ffffc deadbeef f 00000000
W 000204 cafef00d f 00000000
R 7ffffc 00000000 0 deadbeef
R 000204 00000000 0 cafef00d
W 000204 00000000 6 00000000
R 000204 00000000 0 ca00000d
W 001000 0badc0de f 00000000
R 001000 00000000 0 0badc0de
W 001000 ffffffff 4 00000000
R 001000 00000000 0 0bffc0de
